/* src/cpu_pkg.sv */
package cpu_pkg;

    localparam int data_w     = 8;    // data and address width
    localparam int reg_addr_w = 2;    // R0..R3
    localparam int opcode_w   = 4;
    localparam int mem_depth  = 256;  // full 8-bit address space

    // opcodes, anything unlisted behaves as nop
    localparam logic [opcode_w-1:0] op_nop = 4'd0;
    localparam logic [opcode_w-1:0] op_mov = 4'd1;   // ra <- rb
    localparam logic [opcode_w-1:0] op_add = 4'd2;   // ra <- ra + rb, all flags
    localparam logic [opcode_w-1:0] op_sub = 4'd3;   // ra <- ra - rb, all flags
    localparam logic [opcode_w-1:0] op_and = 4'd4;   // z and n only
    localparam logic [opcode_w-1:0] op_or  = 4'd5;   // z and n only
    localparam logic [opcode_w-1:0] op_out = 4'd7;   // port <- rb
    localparam logic [opcode_w-1:0] op_in  = 4'd8;   // ra <- port
    localparam logic [opcode_w-1:0] op_jz  = 4'd9;   // pc <- rb if z
    localparam logic [opcode_w-1:0] op_jmp = 4'd10;  // pc <- rb
    localparam logic [opcode_w-1:0] op_ldm = 4'd11;  // ra <- next byte
    localparam logic [opcode_w-1:0] op_ldd = 4'd12;  // ra <- mem[rb]
    localparam logic [opcode_w-1:0] op_std = 4'd13;  // mem[rb] <- ra

    // write-back source
    localparam logic [1:0] wb_sel_alu = 2'd0;
    localparam logic [1:0] wb_sel_mem = 2'd1;

    // operand forwarding source
    localparam logic [1:0] fwd_none  = 2'd0;
    localparam logic [1:0] fwd_exmem = 2'd1;
    localparam logic [1:0] fwd_memwb = 2'd2;

    localparam string program_file = "tb/program.hex";  // relative to run dir

    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
    } instr_fields_t;

    // byte after op_ldm is data, so the IF/ID word has two views
    typedef union packed {
        instr_fields_t     fields;
        logic [data_w-1:0] imm;
    } instr_word_t;

endpackage

/* src/fetch_stage.sv */
module fetch_stage
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              branch_taken,
    input  logic [data_w-1:0] branch_target,
    input  logic [data_w-1:0] fetch_word,
    output logic [data_w-1:0] fetch_addr,
    output instr_word_t       ifid_word
);

    logic [data_w-1:0] pc;

    assign fetch_addr = pc;  // memory read is combinational

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            ifid_word <= '0;                      // all-zero word is a nop
        end else if (branch_taken) begin
            pc        <= branch_target;           // redirect from execute
            ifid_word <= '0;                      // drop the word in flight
        end else if (!stall) begin
            pc        <= pc + 1'b1;
            ifid_word <= instr_word_t'(fetch_word);
        end
    end

endmodule

/* src/decode_unit.sv */
module decode_unit
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  branch_taken,
    input  instr_word_t           ifid_word,
    output logic                  reg_write,
    output logic                  mem_write,
    output logic                  mem_read,
    output logic                  flag_en,
    output logic                  is_jz,
    output logic                  is_jmp,
    output logic                  is_in,
    output logic                  is_out,
    output logic [opcode_w-1:0]   alu_op,
    output logic [1:0]            wb_sel,
    output logic [reg_addr_w-1:0] ra,
    output logic [reg_addr_w-1:0] rb,
    output logic [reg_addr_w-1:0] dest,
    output logic                  uses_ra,
    output logic                  uses_rb,
    output logic                  imm_valid,
    output logic [data_w-1:0]     imm_value
);

    logic                  imm_pending;   // current word is ldm data
    logic [reg_addr_w-1:0] pending_dest;  // ra of that ldm
    logic [opcode_w-1:0]   opcode;

    assign opcode    = ifid_word.fields.opcode;
    assign ra        = ifid_word.fields.ra;
    assign rb        = ifid_word.fields.rb;
    assign imm_value = ifid_word.imm;  // byte view of the same word
    assign imm_valid = imm_pending;

    always_comb begin
        reg_write = 1'b0;
        mem_write = 1'b0;
        mem_read  = 1'b0;
        flag_en   = 1'b0;
        is_jz     = 1'b0;
        is_jmp    = 1'b0;
        is_in     = 1'b0;
        is_out    = 1'b0;
        uses_ra   = 1'b0;
        uses_rb   = 1'b0;
        wb_sel    = wb_sel_alu;
        alu_op    = opcode;
        dest      = ra;
        if (imm_pending) begin
            reg_write = 1'b1;             // second half of ldm
            alu_op    = op_nop;
            dest      = pending_dest;
        end else begin
            case (opcode)
                op_mov: begin
                    reg_write = 1'b1;
                    uses_rb   = 1'b1;
                end
                op_add, op_sub, op_and, op_or: begin
                    reg_write = 1'b1;
                    flag_en   = 1'b1;
                    uses_ra   = 1'b1;
                    uses_rb   = 1'b1;
                end
                op_out: begin
                    is_out  = 1'b1;
                    uses_rb = 1'b1;
                end
                op_in:  reg_write = 1'b1;
                op_jz: begin
                    is_jz   = 1'b1;
                    uses_rb = 1'b1;
                end
                op_jmp: begin
                    is_jmp  = 1'b1;
                    uses_rb = 1'b1;
                end
                op_ldd: begin
                    reg_write = 1'b1;
                    mem_read  = 1'b1;
                    wb_sel    = wb_sel_mem;
                    uses_rb   = 1'b1;
                end
                op_std: begin
                    mem_write = 1'b1;
                    uses_ra   = 1'b1;
                    uses_rb   = 1'b1;
                end
                default: ;                // nop, ldm first byte is a bubble
            endcase
        end
        is_in = !imm_pending && opcode == op_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imm_pending  <= 1'b0;
            pending_dest <= '0;
        end else if (branch_taken) begin
            imm_pending  <= 1'b0;         // flushed ldm loses its data byte
        end else if (!stall) begin
            imm_pending  <= !imm_pending && opcode == op_ldm;
            pending_dest <= ra;
        end
    end

endmodule

/* src/register_file.sv */
module register_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [data_w-1:0]     wb_data,
    output logic [data_w-1:0]     ra_val,
    output logic [data_w-1:0]     rb_val
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // write-first bypass, covers the writer three slots ahead
    assign ra_val = (wb_we && wb_dest == ra) ? wb_data : regs[ra];
    assign rb_val = (wb_we && wb_dest == rb) ? wb_data : regs[rb];

endmodule

/* src/hazard_unit.sv */
module hazard_unit
    import cpu_pkg::*;
(
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    input  logic                  uses_ra,
    input  logic                  uses_rb,
    input  logic [reg_addr_w-1:0] idex_dest,
    input  logic                  idex_mem_read,
    input  logic [reg_addr_w-1:0] idex_ra,
    input  logic [reg_addr_w-1:0] idex_rb,
    input  logic [reg_addr_w-1:0] exmem_dest,
    input  logic                  exmem_reg_write,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic                  wb_we,
    output logic                  stall,
    output logic [1:0]            fwd_a,
    output logic [1:0]            fwd_b
);

    // youngest writer first
    function automatic logic [1:0] pick_src(input logic [reg_addr_w-1:0] src,
                                            input logic [reg_addr_w-1:0] mem_dest,
                                            input logic                  mem_we,
                                            input logic [reg_addr_w-1:0] last_dest,
                                            input logic                  last_we);
        logic [1:0] sel;
        sel = fwd_none;
        if (mem_we && mem_dest == src) begin
            sel = fwd_exmem;
        end else if (last_we && last_dest == src) begin
            sel = fwd_memwb;
        end
        return sel;
    endfunction

    // load data is not there until MEM/WB, so hold decode one cycle
    assign stall = idex_mem_read &&
                   ((uses_ra && ra == idex_dest) || (uses_rb && rb == idex_dest));

    assign fwd_a = pick_src(idex_ra, exmem_dest, exmem_reg_write, wb_dest, wb_we);
    assign fwd_b = pick_src(idex_rb, exmem_dest, exmem_reg_write, wb_dest, wb_we);

endmodule

/* src/execute_stage.sv */
module execute_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  reg_write,
    input  logic                  mem_write,
    input  logic                  mem_read,
    input  logic                  flag_en,
    input  logic                  is_jz,
    input  logic                  is_jmp,
    input  logic                  is_in,
    input  logic                  is_out,
    input  logic [opcode_w-1:0]   alu_op,
    input  logic [1:0]            wb_sel,
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    input  logic [reg_addr_w-1:0] dest,
    input  logic                  imm_valid,
    input  logic [data_w-1:0]     imm_value,
    input  logic [data_w-1:0]     ra_val,
    input  logic [data_w-1:0]     rb_val,
    input  logic [1:0]            fwd_a,
    input  logic [1:0]            fwd_b,
    input  logic [data_w-1:0]     wb_data,
    input  logic [data_w-1:0]     in_port,
    output logic [reg_addr_w-1:0] idex_dest,
    output logic                  idex_mem_read,
    output logic [reg_addr_w-1:0] idex_ra,
    output logic [reg_addr_w-1:0] idex_rb,
    output logic                  branch_taken,
    output logic [data_w-1:0]     branch_target,
    output logic [data_w-1:0]     exmem_result,
    output logic [data_w-1:0]     exmem_store_data,
    output logic [data_w-1:0]     exmem_addr,
    output logic [reg_addr_w-1:0] exmem_dest,
    output logic                  exmem_reg_write,
    output logic                  exmem_mem_write,
    output logic [1:0]            exmem_wb_sel,
    output logic                  exmem_out_en
);

    logic                bubble;
    logic                idex_reg_write;
    logic                idex_mem_write;
    logic                idex_flag_en;
    logic                idex_is_jz;
    logic                idex_is_jmp;
    logic                idex_is_in;
    logic                idex_is_out;
    logic                idex_imm_valid;
    logic [opcode_w-1:0] idex_alu_op;
    logic [1:0]          idex_wb_sel;
    logic [data_w-1:0]   idex_a;
    logic [data_w-1:0]   idex_b;
    logic [data_w-1:0]   idex_imm;
    logic [data_w-1:0]   op_a;
    logic [data_w-1:0]   op_b;
    logic [data_w-1:0]   result;
    logic [data_w:0]     sum;         // extra bit is carry/borrow
    logic [3:0]          flags;       // {v, c, n, z}
    logic [3:0]          flags_next;

    function automatic logic [data_w-1:0] fwd_mux(input logic [1:0]        sel,
                                                  input logic [data_w-1:0] stored,
                                                  input logic [data_w-1:0] from_mem,
                                                  input logic [data_w-1:0] from_wb);
        logic [data_w-1:0] value;
        case (sel)
            fwd_exmem: value = from_mem;
            fwd_memwb: value = from_wb;
            default:   value = stored;
        endcase
        return value;
    endfunction

    assign bubble = stall || branch_taken;  // flush and load-use both squash

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_reg_write <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_flag_en   <= 1'b0;
            idex_is_jz     <= 1'b0;
            idex_is_jmp    <= 1'b0;
            idex_is_in     <= 1'b0;
            idex_is_out    <= 1'b0;
            idex_imm_valid <= 1'b0;
            idex_alu_op    <= op_nop;
            idex_wb_sel    <= wb_sel_alu;
        end else begin
            idex_reg_write <= reg_write && !bubble;
            idex_mem_write <= mem_write && !bubble;
            idex_mem_read  <= mem_read && !bubble;
            idex_flag_en   <= flag_en && !bubble;
            idex_is_jz     <= is_jz && !bubble;
            idex_is_jmp    <= is_jmp && !bubble;
            idex_is_in     <= is_in && !bubble;
            idex_is_out    <= is_out && !bubble;
            idex_imm_valid <= imm_valid && !bubble;
            idex_alu_op    <= alu_op;
            idex_wb_sel    <= wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        idex_a    <= ra_val;
        idex_b    <= rb_val;
        idex_imm  <= imm_value;
        idex_ra   <= ra;
        idex_rb   <= rb;
        idex_dest <= dest;
    end

    assign op_a = fwd_mux(fwd_a, idex_a, exmem_result, wb_data);
    assign op_b = fwd_mux(fwd_b, idex_b, exmem_result, wb_data);

    always_comb begin
        sum        = '0;
        flags_next = flags;               // logic ops keep c and v
        if (idex_imm_valid) begin
            result = idex_imm;
        end else if (idex_is_in) begin
            result = in_port;
        end else begin
            case (idex_alu_op)
                op_add: begin
                    sum           = {1'b0, op_a} + {1'b0, op_b};
                    result        = sum[data_w-1:0];
                    flags_next[2] = sum[data_w];
                    flags_next[3] = (op_a[data_w-1] == op_b[data_w-1]) &&
                                    (result[data_w-1] != op_a[data_w-1]);
                end
                op_sub: begin
                    sum           = {1'b0, op_a} - {1'b0, op_b};
                    result        = sum[data_w-1:0];
                    flags_next[2] = sum[data_w];  // borrow
                    flags_next[3] = (op_a[data_w-1] != op_b[data_w-1]) &&
                                    (result[data_w-1] != op_a[data_w-1]);
                end
                op_and:  result = op_a & op_b;
                op_or:   result = op_a | op_b;
                default: result = op_b;   // mov
            endcase
        end
        flags_next[0] = (result == '0);
        flags_next[1] = result[data_w-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (idex_flag_en) begin
            flags <= flags_next;
        end
    end

    // flags already hold the result of older instructions
    assign branch_taken  = idex_is_jmp || (idex_is_jz && flags[0]);
    assign branch_target = op_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_reg_write <= 1'b0;
            exmem_mem_write <= 1'b0;
            exmem_wb_sel    <= wb_sel_alu;
            exmem_out_en    <= 1'b0;
        end else begin
            exmem_reg_write <= idex_reg_write;
            exmem_mem_write <= idex_mem_write;
            exmem_wb_sel    <= idex_wb_sel;
            exmem_out_en    <= idex_is_out;
        end
    end

    always_ff @(posedge clk) begin
        exmem_result     <= result;
        exmem_store_data <= idex_is_out ? op_b : op_a;  // out sends rb, std stores ra
        exmem_addr       <= op_b;
        exmem_dest       <= idex_dest;
    end

endmodule

/* src/unified_memory.sv */
module unified_memory
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic [data_w-1:0] fetch_addr,
    input  logic [data_w-1:0] data_addr,
    input  logic [data_w-1:0] data_wdata,
    input  logic              data_we,
    output logic [data_w-1:0] fetch_word,
    output logic [data_w-1:0] data_rdata
);

    logic [data_w-1:0] mem [mem_depth];

    initial begin
        $readmemh(program_file, mem);  // code and data share one image
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
    end

    // both reads are asynchronous
    assign fetch_word = mem[fetch_addr];
    assign data_rdata = mem[data_addr];

endmodule

/* src/writeback_stage.sv */
module writeback_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [data_w-1:0]     exmem_result,
    input  logic [data_w-1:0]     exmem_store_data,
    input  logic [reg_addr_w-1:0] exmem_dest,
    input  logic                  exmem_reg_write,
    input  logic [1:0]            exmem_wb_sel,
    input  logic                  exmem_out_en,
    input  logic [data_w-1:0]     mem_rdata,
    output logic [data_w-1:0]     wb_data,
    output logic [reg_addr_w-1:0] wb_dest,
    output logic                  wb_we,
    output logic [data_w-1:0]     out_port
);

    logic              memwb_out_en;
    logic [1:0]        memwb_wb_sel;
    logic [data_w-1:0] memwb_result;
    logic [data_w-1:0] memwb_rdata;
    logic [data_w-1:0] memwb_out_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we        <= 1'b0;
            memwb_out_en <= 1'b0;
            memwb_wb_sel <= wb_sel_alu;
        end else begin
            wb_we        <= exmem_reg_write;
            memwb_out_en <= exmem_out_en;
            memwb_wb_sel <= exmem_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        memwb_result   <= exmem_result;
        memwb_rdata    <= mem_rdata;        // load data captured here
        memwb_out_data <= exmem_store_data;
        wb_dest        <= exmem_dest;
    end

    assign wb_data = (memwb_wb_sel == wb_sel_mem) ? memwb_rdata : memwb_result;

    // port updates the cycle after out reaches write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_port <= '0;
        end else if (memwb_out_en) begin
            out_port <= memwb_out_data;
        end
    end

endmodule

/* src/cpu_core.sv */
module cpu_core
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] in_port,
    output logic [data_w-1:0] out_port
);

    // fetch <-> memory
    logic [data_w-1:0]     fetch_addr;
    logic [data_w-1:0]     fetch_word;
    instr_word_t           ifid_word;

    // decode outputs
    logic                  reg_write;
    logic                  mem_write;
    logic                  mem_read;
    logic                  flag_en;
    logic                  is_jz;
    logic                  is_jmp;
    logic                  is_in;
    logic                  is_out;
    logic [opcode_w-1:0]   alu_op;
    logic [1:0]            wb_sel;
    logic [reg_addr_w-1:0] ra;
    logic [reg_addr_w-1:0] rb;
    logic [reg_addr_w-1:0] dest;
    logic                  uses_ra;
    logic                  uses_rb;
    logic                  imm_valid;
    logic [data_w-1:0]     imm_value;

    logic [data_w-1:0]     ra_val;  // regfile reads
    logic [data_w-1:0]     rb_val;

    // hazard and forwarding
    logic                  stall;
    logic [1:0]            fwd_a;
    logic [1:0]            fwd_b;
    logic [reg_addr_w-1:0] idex_dest;
    logic                  idex_mem_read;
    logic [reg_addr_w-1:0] idex_ra;
    logic [reg_addr_w-1:0] idex_rb;

    logic                  branch_taken;  // redirect + flush
    logic [data_w-1:0]     branch_target;

    // EX/MEM
    logic [data_w-1:0]     exmem_result;
    logic [data_w-1:0]     exmem_store_data;
    logic [data_w-1:0]     exmem_addr;
    logic [reg_addr_w-1:0] exmem_dest;
    logic                  exmem_reg_write;
    logic                  exmem_mem_write;
    logic [1:0]            exmem_wb_sel;
    logic                  exmem_out_en;
    logic [data_w-1:0]     mem_rdata;

    // write-back
    logic [data_w-1:0]     wb_data;
    logic [reg_addr_w-1:0] wb_dest;
    logic                  wb_we;

    fetch_stage     fetch_stage_inst     (.*);
    decode_unit     decode_unit_inst     (.*);
    register_file   register_file_inst   (.*);
    hazard_unit     hazard_unit_inst     (.*);
    execute_stage   execute_stage_inst   (.*);
    writeback_stage writeback_stage_inst (.*);

    unified_memory unified_memory_inst (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .data_addr  (exmem_addr),        // memory stage port
        .data_wdata (exmem_store_data),
        .data_we    (exmem_mem_write),
        .data_rdata (mem_rdata)
    );

endmodule

/* tb/tb_cpu_core.sv */
module tb_cpu_core
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rows        = 6;
    localparam int clk_period      = 10;
    localparam int reset_cycles    = 8;
    localparam int wait_limit      = 200;                  // cycles per expected output
    localparam int watchdog_cycles = (num_rows + 1) * 500; // one spare row of margin

    logic              clk;
    logic              rst_n;
    logic [data_w-1:0] in_port;
    logic [data_w-1:0] out_port;

    // stimulus table, expected columns filled from the program's rule
    string             row_name [num_rows];
    logic [data_w-1:0] row_x    [num_rows];
    logic [data_w-1:0] row_a    [num_rows];
    logic [data_w-1:0] row_b    [num_rows];

    int pass_count;
    int fail_count;
    int seed;

    cpu_core cpu_core_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_port  (in_port),
        .out_port (out_port)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // first output of a pass, wraps at 8 bits
    function automatic logic [data_w-1:0] sum_output(input logic [data_w-1:0] x);
        return x + 8'h3c;
    endfunction

    // second output, 0xff only when 0x5a - x hits zero
    function automatic logic [data_w-1:0] branch_output(input logic [data_w-1:0] x);
        return (x == 8'h5a) ? 8'hff : x;
    endfunction

    task automatic add_row(input int idx, input string name, input logic [data_w-1:0] x);
        row_name[idx] = name;
        row_x[idx]    = x;
        row_a[idx]    = sum_output(x);
        row_b[idx]    = branch_output(x);
    endtask

    task automatic build_table();
        logic [data_w-1:0] rand_0;
        logic [data_w-1:0] rand_1;
        rand_0 = 8'($random(seed));
        rand_1 = 8'($random(seed));
        add_row(0, "zero", 8'h00);
        add_row(1, "jz_taken", 8'h5a);   // only row that takes the branch
        add_row(2, "wrap", 8'hc4);       // A wraps to 0x00
        add_row(3, "pos_max", 8'h7f);
        add_row(4, "rand_0", rand_0);
        add_row(5, "rand_1", rand_1);
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("test %-8s ok", name);
        end else begin
            fail_count++;
            $display("test %-8s failed", name);
        end
    endtask

    // poll once per cycle, sampled 1 ns after the edge
    task automatic wait_for_output(input logic [data_w-1:0] expected, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            found = (out_port == expected);
            cycles++;
        end
    endtask

    // stops on the first value that differs from old_value
    task automatic wait_for_change(input logic [data_w-1:0] old_value, output bit changed);
        int cycles;
        changed = 1'b0;
        cycles  = 0;
        while (!changed && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            changed = (out_port !== old_value);
            cycles++;
        end
    endtask

    task automatic check_output(input string name, input string label,
                                input logic [data_w-1:0] expected, output bit ok);
        bit found;
        wait_for_output(expected, found);
        ok = found;
        assert (found) else begin
            $display("Error: %s %s expected 0x%02h actual 0x%02h, timed out waiting for output",
                     name, label, expected, out_port);
        end
    endtask

    // B is the very next port value after A
    // a wrong-path out would land in between
    task automatic check_next_output(input string name, input logic [data_w-1:0] prev,
                                     input logic [data_w-1:0] expected, output bit ok);
        bit changed;
        wait_for_change(prev, changed);
        ok = changed && (out_port === expected);
        assert (changed) else begin
            $display("%s B: out_port stayed at 0x%02h, timed out waiting for output",
                     name, prev);
        end
        if (changed) begin
            assert (ok) else begin
                $display("Error: %s B expected 0x%02h actual 0x%02h",
                         name, expected, out_port);
            end
        end
    endtask

    // port must stay cleared until the first out reaches it
    task automatic check_reset();
        bit ok;
        ok = (out_port == 8'h00);
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1;
            ok = ok && (out_port == 8'h00);
        end
        assert (ok) else begin
            $display("Error: reset out_port expected 0x00 actual 0x%02h", out_port);
        end
        report_test("reset", ok);
    endtask

    task automatic run_row(input int idx);
        bit ok_a;
        bit ok_b;
        in_port = row_x[idx];              // picked up by the next in r0
        check_output(row_name[idx], "A", row_a[idx], ok_a);
        if (ok_a) begin
            check_next_output(row_name[idx], row_a[idx], row_b[idx], ok_b);
        end else begin
            ok_b = 1'b0;                   // B is meaningless without A
        end
        report_test(row_name[idx], ok_a && ok_b);
    endtask

    initial begin
        seed       = 45030;
        pass_count = 0;
        fail_count = 0;
        rst_n      = 1'b0;
        in_port    = '0;
        build_table();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;                      // released 1 ns after the edge
        check_reset();
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // stops a core that never reaches an expected value
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* build.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_unit.sv
src/register_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/unified_memory.sv
src/writeback_stage.sv
src/cpu_core.sv
tb/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  # package first, then the stages, top level last
  - src/cpu_pkg.sv
  - src/fetch_stage.sv
  - src/decode_unit.sv
  - src/register_file.sv
  - src/hazard_unit.sv
  - src/execute_stage.sv
  - src/unified_memory.sv
  - src/writeback_stage.sv
  - src/cpu_core.sv
  - target: simulation
    files:
      - tb/tb_cpu_core.sv

/* tb/program.hex */
// one byte per line from address 0, @xx moves the load address
// instruction byte is opcode[7:4] ra[3:2] rb[1:0], the byte after ldm is data
80  // 00 in   r0
B4  // 01 ldm  r1
3C  // 02      0x3c
24  // 03 add  r1, r0
B8  // 04 ldm  r2
80  // 05      0x80
D6  // 06 std  [r2], r1
CE  // 07 ldd  r3, [r2]
73  // 08 out  r3
B4  // 09 ldm  r1
5A  // 0a      0x5a
34  // 0b sub  r1, r0
B8  // 0c ldm  r2
13  // 0d      0x13
92  // 0e jz   r2
70  // 0f out  r0
B8  // 10 ldm  r2
00  // 11      0x00
A2  // 12 jmp  r2
BC  // 13 ldm  r3
FF  // 14      0xff
73  // 15 out  r3
B8  // 16 ldm  r2
00  // 17      0x00
A2  // 18 jmp  r2
00  // 19 nop, fetched behind the jump
00  // 1a nop
@80
00  // data byte for the store/load pair
